/* Makefile */
VERILATOR ?= verilator
TOP       := tb_arith_cluster
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* arith_rs/arith_alu.sv */
// Two-stage integer ALU
// Stage one registers the request, stage two computes and registers
// the result tagged with its ROB index. ADDV traps on signed overflow

`timescale 1ns/1ps

module arith_alu
  import arith_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    req_valid_i,
  input  eu_req_t req_i,
  output logic    res_valid_o,
  output eu_res_t res_o
);

  logic            s1_valid_q, s2_valid_q;
  eu_req_t         s1_req_q;
  eu_res_t         s2_res_q;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] alu_result;
  logic            overflow;

  // ----------------------------------------------------------
  // Compute stage
  // ----------------------------------------------------------
  assign sum      = s1_req_q.rs1 + s1_req_q.rs2;
  // Same operand signs, different result sign
  assign overflow = (s1_req_q.rs1[XLEN-1] == s1_req_q.rs2[XLEN-1])
                  & (sum[XLEN-1] != s1_req_q.rs1[XLEN-1]);

  always_comb begin
    case (s1_req_q.op)
      ADD, ADDV: alu_result = sum;
      SUB:       alu_result = s1_req_q.rs1 - s1_req_q.rs2;
      AND:       alu_result = s1_req_q.rs1 & s1_req_q.rs2;
      OR:        alu_result = s1_req_q.rs1 | s1_req_q.rs2;
      XOR:       alu_result = s1_req_q.rs1 ^ s1_req_q.rs2;
      SLL:       alu_result = s1_req_q.rs1 << s1_req_q.rs2[4:0];
      SRL:       alu_result = s1_req_q.rs1 >> s1_req_q.rs2[4:0];
      SLT:       alu_result = {{(XLEN-1){1'b0}},
                               $signed(s1_req_q.rs1) < $signed(s1_req_q.rs2)};
      default:   alu_result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Pipeline registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_req_q               <= req_i;
    s2_res_q.rob_idx       <= s1_req_q.rob_idx;
    s2_res_q.result        <= alu_result;
    s2_res_q.except_raised <= (s1_req_q.op == ADDV) & overflow;
    s2_res_q.except_code   <= ((s1_req_q.op == ADDV) & overflow) ? OVERFLOW : NONE;
  end

  assign res_valid_o = s2_valid_q;
  assign res_o       = s2_res_q;

endmodule

/* arith_rs/arith_rs.sv */
// Arithmetic reservation station
// Holds issued instructions until both operands are known, captures
// pending operands from the CDB or from the ALU result, sends ready
// entries to the ALU and writes finished results back on the CDB

`timescale 1ns/1ps

module arith_rs
  import arith_pkg::*;
#(
  parameter int unsigned DEPTH = RS_DEPTH
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,

  // Issue stage
  input  logic      issue_valid_i,
  output logic      issue_ready_o,
  input  alu_op_t   issue_op_i,
  input  op_data_t  issue_rs1_i,
  input  op_data_t  issue_rs2_i,
  input  rob_idx_t  issue_dest_rob_idx_i,

  // Common data bus
  input  logic      cdb_valid_i,
  input  cdb_data_t cdb_data_i,
  output logic      cdb_valid_o,
  input  logic      cdb_ready_i,
  output cdb_data_t cdb_data_o,

  // Execution unit
  output logic      eu_req_valid_o,
  output eu_req_t   eu_req_o,
  input  logic      eu_res_valid_i,
  input  eu_res_t   eu_res_i
);

  typedef struct packed {
    alu_op_t         op;
    rob_idx_t        rs1_rob_idx;
    logic [XLEN-1:0] rs1_value;
    rob_idx_t        rs2_rob_idx;
    logic [XLEN-1:0] rs2_value;
    rob_idx_t        dest_rob_idx;
    logic [XLEN-1:0] res_value;
    logic            except_raised;
    except_code_t    except_code;
  } rs_entry_t;

  typedef enum logic [2:0] {
    EMPTY,
    RS1_PENDING,
    RS2_PENDING,
    RS12_PENDING,
    EX_REQ,     // Waiting for the ALU slot
    EX_WAIT,    // In flight in the ALU
    COMPLETED   // Waiting for the CDB
  } rs_state_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_INSERT,
    OP_SAVE_RS1,
    OP_SAVE_RS2,
    OP_SAVE_RS12,
    OP_SAVE_RES
  } rs_op_t;

  rs_entry_t                data_q   [DEPTH];
  rs_state_t                state_q  [DEPTH];
  rs_state_t                state_d  [DEPTH];
  rs_op_t                   entry_op [DEPTH];

  logic [DEPTH-1:0]         empty_lines, ex_lines, done_lines;
  logic [$clog2(DEPTH)-1:0] new_idx, ex_idx, cdb_idx;
  logic                     new_valid, ex_valid, done_valid;
  logic                     insert, remove;

  logic                     ins_rs1_eu, ins_rs2_eu;
  logic                     ins_rs1_ok, ins_rs2_ok;
  logic [XLEN-1:0]          ins_rs1_value, ins_rs2_value;
  logic [DEPTH-1:0]         fwd_rs1_eu, fwd_rs2_eu, fwd_rs1, fwd_rs2;

  assign insert = issue_valid_i & issue_ready_o;
  assign remove = cdb_valid_o & cdb_ready_i;

  // ----------------------------------------------------------
  // Operand forwarding
  // ----------------------------------------------------------
  // At insertion, a pending tag may already be on a bus this cycle
  always_comb begin
    ins_rs1_eu = eu_res_valid_i & (eu_res_i.rob_idx == issue_rs1_i.rob_idx);
    ins_rs2_eu = eu_res_valid_i & (eu_res_i.rob_idx == issue_rs2_i.rob_idx);
    ins_rs1_ok = issue_rs1_i.ready | ins_rs1_eu
               | (cdb_valid_i & (cdb_data_i.rob_idx == issue_rs1_i.rob_idx));
    ins_rs2_ok = issue_rs2_i.ready | ins_rs2_eu
               | (cdb_valid_i & (cdb_data_i.rob_idx == issue_rs2_i.rob_idx));
    ins_rs1_value = issue_rs1_i.ready ? issue_rs1_i.value :
                    ins_rs1_eu        ? eu_res_i.result : cdb_data_i.res_value;
    ins_rs2_value = issue_rs2_i.ready ? issue_rs2_i.value :
                    ins_rs2_eu        ? eu_res_i.result : cdb_data_i.res_value;
  end

  // Entries already waiting, ALU broadcast takes priority
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      fwd_rs1_eu[i] = eu_res_valid_i & (eu_res_i.rob_idx == data_q[i].rs1_rob_idx);
      fwd_rs2_eu[i] = eu_res_valid_i & (eu_res_i.rob_idx == data_q[i].rs2_rob_idx);
      fwd_rs1[i]    = fwd_rs1_eu[i]
                    | (cdb_valid_i & (cdb_data_i.rob_idx == data_q[i].rs1_rob_idx));
      fwd_rs2[i]    = fwd_rs2_eu[i]
                    | (cdb_valid_i & (cdb_data_i.rob_idx == data_q[i].rs2_rob_idx));
    end
  end

  // ----------------------------------------------------------
  // Per-entry state machine
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      state_d[i]  = state_q[i];
      entry_op[i] = OP_NONE;
      case (state_q[i])
        EMPTY: begin
          if (insert && int'(new_idx) == i) begin
            entry_op[i] = OP_INSERT;
            case ({ins_rs1_ok, ins_rs2_ok})
              2'b11:   state_d[i] = EX_REQ;
              2'b01:   state_d[i] = RS1_PENDING;
              2'b10:   state_d[i] = RS2_PENDING;
              default: state_d[i] = RS12_PENDING;
            endcase
          end
        end
        RS12_PENDING: begin
          if (fwd_rs1[i] && fwd_rs2[i]) begin
            entry_op[i] = OP_SAVE_RS12;
            state_d[i]  = EX_REQ;
          end else if (fwd_rs1[i]) begin
            entry_op[i] = OP_SAVE_RS1;
            state_d[i]  = RS2_PENDING;
          end else if (fwd_rs2[i]) begin
            entry_op[i] = OP_SAVE_RS2;
            state_d[i]  = RS1_PENDING;
          end
        end
        RS1_PENDING: begin
          if (fwd_rs1[i]) begin
            entry_op[i] = OP_SAVE_RS1;
            state_d[i]  = EX_REQ;
          end
        end
        RS2_PENDING: begin
          if (fwd_rs2[i]) begin
            entry_op[i] = OP_SAVE_RS2;
            state_d[i]  = EX_REQ;
          end
        end
        EX_REQ: begin
          if (eu_req_valid_o && int'(ex_idx) == i) state_d[i] = EX_WAIT;  // ALU never stalls
        end
        EX_WAIT: begin
          if (eu_res_valid_i && eu_res_i.rob_idx == data_q[i].dest_rob_idx) begin
            entry_op[i] = OP_SAVE_RES;
            state_d[i]  = COMPLETED;
          end
        end
        COMPLETED: begin
          if (remove && int'(cdb_idx) == i) state_d[i] = EMPTY;
        end
        default: state_d[i] = EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) state_q[i] <= EMPTY;
    end else if (flush_i) begin
      for (int i = 0; i < DEPTH; i++) state_q[i] <= EMPTY;
    end else begin
      for (int i = 0; i < DEPTH; i++) state_q[i] <= state_d[i];
    end
  end

  // ----------------------------------------------------------
  // Entry buffer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (entry_op[i] == OP_INSERT) begin
        data_q[i].op           <= issue_op_i;
        data_q[i].rs1_rob_idx  <= issue_rs1_i.rob_idx;
        data_q[i].rs1_value    <= ins_rs1_value;
        data_q[i].rs2_rob_idx  <= issue_rs2_i.rob_idx;
        data_q[i].rs2_value    <= ins_rs2_value;
        data_q[i].dest_rob_idx <= issue_dest_rob_idx_i;
      end
      if (entry_op[i] == OP_SAVE_RS1 || entry_op[i] == OP_SAVE_RS12) begin
        data_q[i].rs1_value <= fwd_rs1_eu[i] ? eu_res_i.result : cdb_data_i.res_value;
      end
      if (entry_op[i] == OP_SAVE_RS2 || entry_op[i] == OP_SAVE_RS12) begin
        data_q[i].rs2_value <= fwd_rs2_eu[i] ? eu_res_i.result : cdb_data_i.res_value;
      end
      if (entry_op[i] == OP_SAVE_RES) begin
        data_q[i].res_value     <= eu_res_i.result;
        data_q[i].except_raised <= eu_res_i.except_raised;
        data_q[i].except_code   <= eu_res_i.except_code;
      end
    end
  end

  // ----------------------------------------------------------
  // Entry selection and outputs
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      empty_lines[i] = (state_q[i] == EMPTY);
      ex_lines[i]    = (state_q[i] == EX_REQ);
      done_lines[i]  = (state_q[i] == COMPLETED);
    end
  end

  prio_enc #(.N(DEPTH)) new_sel (
    .lines_i (empty_lines),
    .enc_o   (new_idx),
    .valid_o (new_valid)
  );

  prio_enc #(.N(DEPTH)) ex_sel (
    .lines_i (ex_lines),
    .enc_o   (ex_idx),
    .valid_o (ex_valid)
  );

  prio_enc #(.N(DEPTH)) cdb_sel (
    .lines_i (done_lines),
    .enc_o   (cdb_idx),
    .valid_o (done_valid)
  );

  assign issue_ready_o = new_valid;  // Any free slot

  assign eu_req_valid_o   = ex_valid;
  assign eu_req_o.op      = data_q[ex_idx].op;
  assign eu_req_o.rs1     = data_q[ex_idx].rs1_value;
  assign eu_req_o.rs2     = data_q[ex_idx].rs2_value;
  assign eu_req_o.rob_idx = data_q[ex_idx].dest_rob_idx;

  // Lowest completed entry holds its data until the arbiter takes it
  assign cdb_valid_o              = done_valid;
  assign cdb_data_o.rob_idx       = data_q[cdb_idx].dest_rob_idx;
  assign cdb_data_o.res_value     = data_q[cdb_idx].res_value;
  assign cdb_data_o.except_raised = data_q[cdb_idx].except_raised;
  assign cdb_data_o.except_code   = data_q[cdb_idx].except_code;

endmodule

/* common/arith_pkg.sv */
// Arithmetic issue cluster shared definitions
// Widths, ROB tags, operand and CDB payloads, ALU operations and
// exception codes used by the reservation station and the ALU

package arith_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int unsigned XLEN        = 32;  // Operand and result width
  localparam int unsigned ROB_IDX_LEN = 4;
  localparam int unsigned RS_DEPTH    = 4;   // Power of two

  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // One issued source operand, either a value or a pending tag
  typedef struct packed {
    logic            ready;
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] value;
  } op_data_t;

  // ----------------------------------------------------------
  // Operations and exceptions
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SLT,
    ADDV   // Add, traps on signed overflow
  } alu_op_t;

  typedef enum logic [3:0] {
    NONE     = 4'h0,
    OVERFLOW = 4'h1
  } except_code_t;

  // ----------------------------------------------------------
  // Bus payloads
  // ----------------------------------------------------------
  typedef struct packed {
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] res_value;
    logic            except_raised;
    except_code_t    except_code;
  } cdb_data_t;

  // Station to ALU
  typedef struct packed {
    alu_op_t         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    rob_idx_t        rob_idx;
  } eu_req_t;

  // ALU to station, also seen by the forwarding logic
  typedef struct packed {
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] result;
    logic            except_raised;
    except_code_t    except_code;
  } eu_res_t;

endpackage

/* dv/tb_arith_ref.svh */
// Arithmetic cluster testbench reference model
// Expected CDB payload for one operation and typed compare tasks

`ifndef TB_ARITH_REF_SVH
`define TB_ARITH_REF_SVH

// Result, flag and code from the ALU operation rules
function automatic cdb_data_t alu_ref(alu_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  cdb_data_t     r;
  logic [XLEN:0] wide;
  r.rob_idx       = '0;          // Filled in by the caller
  r.except_raised = 1'b0;
  r.except_code   = NONE;
  wide            = {a[XLEN-1], a} + {b[XLEN-1], b};  // Sign-extended sum
  case (op)
    ADD:     r.res_value = a + b;
    SUB:     r.res_value = a - b;
    AND:     r.res_value = a & b;
    OR:      r.res_value = a | b;
    XOR:     r.res_value = a ^ b;
    SLL:     r.res_value = a << b[4:0];
    SRL:     r.res_value = a >> b[4:0];
    SLT:     r.res_value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    ADDV: begin
      r.res_value = wide[XLEN-1:0];
      if (wide[XLEN] != wide[XLEN-1]) begin  // Sign bit lost
        r.except_raised = 1'b1;
        r.except_code   = OVERFLOW;
      end
    end
    default: r.res_value = '0;
  endcase
  return r;
endfunction

task automatic check_cdb(input string name, input cdb_data_t got, input cdb_data_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    abort_run("CDB payload mismatch");
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    abort_run("Handshake flag mismatch");
  end
endtask

`endif

/* dv/tb_arith_cluster.sv */
// Arithmetic cluster testbench
// Plays the issue stage, the external CDB producers and the CDB
// arbiter, and scores every CDB result against a reference model

`timescale 1ns/1ps

module tb_arith_cluster
  import arith_pkg::*;
();

  localparam int N_RAND    = 32;
  localparam int NUM_ISSUE = N_RAND + 4 + 4 + 3 + RS_DEPTH + 3 + 2;

  logic      clk_i, rst_ni, flush_i;
  logic      issue_valid_i, issue_ready_o;
  alu_op_t   issue_op_i;
  op_data_t  issue_rs1_i, issue_rs2_i;
  rob_idx_t  issue_dest_rob_idx_i;
  logic      cdb_valid_i, cdb_valid_o, cdb_ready_i;
  cdb_data_t cdb_data_i, cdb_data_o;

  cdb_data_t exp_tab     [16];  // Expected result per ROB tag
  logic      exp_pending [16];
  int        issued_count, done_count, flushed_count;
  logic      held;              // Output stalled on the last edge
  cdb_data_t held_data;
  integer    seed;

  arith_cluster UUT (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("Simulation failed");
    $fatal(1, "%s", reason);
  endtask

  `include "tb_arith_ref.svh"

  // ----------------------------------------------------------
  // Stimulus helpers called just after a falling edge
  // ----------------------------------------------------------
  function automatic op_data_t ready_op(logic [XLEN-1:0] v);
    op_data_t o;
    o.ready   = 1'b1;
    o.rob_idx = '0;
    o.value   = v;
    return o;
  endfunction

  function automatic op_data_t wait_op(rob_idx_t tag);
    op_data_t o;
    o.ready   = 1'b0;
    o.rob_idx = tag;
    o.value   = '0;
    return o;
  endfunction

  task automatic issue_instr(input alu_op_t op, input op_data_t rs1, input op_data_t rs2,
                             input rob_idx_t dest, input cdb_data_t exp);
    logic accepted;
    while (exp_pending[dest]) @(negedge clk_i);  // Tag still in use
    issue_valid_i        = 1'b1;
    issue_op_i           = op;
    issue_rs1_i          = rs1;
    issue_rs2_i          = rs2;
    issue_dest_rob_idx_i = dest;
    do begin
      accepted = issue_ready_o;  // Stable until the next rising edge
      @(negedge clk_i);
    end while (!accepted);
    issue_valid_i     = 1'b0;
    exp.rob_idx       = dest;
    exp_tab[dest]     = exp;
    exp_pending[dest] = 1'b1;
    issued_count++;
  endtask

  task automatic send_ready_instr(input alu_op_t op, input logic [XLEN-1:0] a,
                                  input logic [XLEN-1:0] b, input rob_idx_t dest);
    issue_instr(op, ready_op(a), ready_op(b), dest, alu_ref(op, a, b));
  endtask

  task automatic broadcast_tag(input rob_idx_t tag, input logic [XLEN-1:0] v);
    cdb_valid_i              = 1'b1;
    cdb_data_i.rob_idx       = tag;
    cdb_data_i.res_value     = v;
    cdb_data_i.except_raised = 1'b0;
    cdb_data_i.except_code   = NONE;
    @(negedge clk_i);
    cdb_valid_i = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic drain_all();
    while (done_count + flushed_count != issued_count) @(negedge clk_i);
  endtask

  // ----------------------------------------------------------
  // CDB monitor and scoreboard
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (held) begin  // Stalled output must not move
        check_bit("cdb_valid_o", cdb_valid_o, 1'b1);
        check_cdb("cdb_data_o", cdb_data_o, held_data);
      end
      if (cdb_valid_o && cdb_ready_i) begin
        if (!exp_pending[cdb_data_o.rob_idx])
          abort_run($sformatf("CDB result for tag %0d with no pending instruction",
                              cdb_data_o.rob_idx));
        check_cdb("cdb_data_o", cdb_data_o, exp_tab[cdb_data_o.rob_idx]);
        exp_pending[cdb_data_o.rob_idx] = 1'b0;
        done_count++;
      end
      held      = cdb_valid_o && !cdb_ready_i && !flush_i;
      held_data = cdb_data_o;
    end
  end

  initial begin
    repeat (NUM_ISSUE * 200 + 1000) @(posedge clk_i);
    abort_run("Watchdog expired before all tests finished");
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [3:0]      op_sel;
    logic [XLEN-1:0] a, b;
    logic [XLEN-1:0] ext_val [4];
    cdb_data_t       prod;
    int              base;
    seed = 32'h45723c01;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i = ADD;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    issue_dest_rob_idx_i = '0;
    cdb_valid_i = 1'b0;
    cdb_data_i = '0;
    cdb_ready_i = 1'b1;
    held = 1'b0;
    held_data = '0;
    issued_count = 0;
    done_count = 0;
    flushed_count = 0;
    for (int t = 0; t < 16; t++) exp_pending[t] = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("issue_ready_o", issue_ready_o, 1'b1);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b0);

    // Random ops with both operands ready
    for (int i = 0; i < N_RAND; i++) begin
      op_sel = 4'($unsigned($random(seed)) % 9);
      a = $random(seed);
      b = $random(seed);
      send_ready_instr(alu_op_t'(op_sel), a, b, rob_idx_t'(i % 12));
    end
    drain_all();

    // Operands from external producers on tags 12 to 15
    for (int k = 0; k < 4; k++) ext_val[k] = $random(seed);
    base = done_count;
    issue_instr(ADD, wait_op(4'd12), ready_op(32'h10), 4'd0, alu_ref(ADD, ext_val[0], 32'h10));
    issue_instr(SUB, ready_op(32'h1000), wait_op(4'd13), 4'd1,
                alu_ref(SUB, 32'h1000, ext_val[1]));
    issue_instr(XOR, wait_op(4'd14), wait_op(4'd15), 4'd2, alu_ref(XOR, ext_val[2], ext_val[3]));
    issue_instr(SLT, wait_op(4'd13), wait_op(4'd12), 4'd3, alu_ref(SLT, ext_val[1], ext_val[0]));
    wait_cycles(10);
    if (done_count != base) abort_run("Instruction completed before its operand was broadcast");
    for (int k = 0; k < 4; k++) broadcast_tag(rob_idx_t'(12 + k), ext_val[k]);
    drain_all();

    // Consumer issued right behind its producer
    a = $random(seed);
    b = $random(seed);
    prod = alu_ref(SUB, a, b);
    send_ready_instr(SUB, a, b, 4'd4);
    issue_instr(ADD, wait_op(4'd4), ready_op(32'h5), 4'd5, alu_ref(ADD, prod.res_value, 32'h5));
    prod = alu_ref(XOR, a, b);
    send_ready_instr(XOR, a, b, 4'd6);
    issue_instr(SRL, ready_op(32'h8000_0000), wait_op(4'd6), 4'd7,
                alu_ref(SRL, 32'h8000_0000, prod.res_value));
    drain_all();

    // Signed overflow on ADDV
    send_ready_instr(ADDV, 32'h7fff_ffff, 32'h1, 4'd8);
    send_ready_instr(ADDV, 32'h5, 32'h7, 4'd9);
    send_ready_instr(ADDV, 32'h8000_0000, 32'hffff_ffff, 4'd10);
    drain_all();

    // Back-pressure until the station is full
    cdb_ready_i = 1'b0;
    for (int k = 0; k < RS_DEPTH; k++) send_ready_instr(ADD, $random(seed), $random(seed),
                                                       rob_idx_t'(k));
    check_bit("issue_ready_o", issue_ready_o, 1'b0);
    wait_cycles(12);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b1);
    cdb_ready_i = 1'b1;
    drain_all();

    // Flush with work in the ALU pipeline
    cdb_ready_i = 1'b0;
    for (int k = 8; k < 11; k++) send_ready_instr(OR, $random(seed), $random(seed),
                                                 rob_idx_t'(k));
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    for (int k = 8; k < 11; k++) exp_pending[k] = 1'b0;
    flushed_count += 3;
    check_bit("issue_ready_o", issue_ready_o, 1'b1);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
    cdb_ready_i = 1'b1;
    wait_cycles(12);
    check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
    send_ready_instr(SLL, 32'h1234_5678, 32'h24, 4'd11);
    send_ready_instr(SUB, 32'h0, 32'h1, 4'd0);
    drain_all();

    wait_cycles(4);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* source/arith_cluster.sv */
// Arithmetic issue cluster top level
// Reservation station feeding a two-stage ALU, with results
// returned to the station and written out on the CDB

`timescale 1ns/1ps

module arith_cluster
  import arith_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,

  input  logic      issue_valid_i,
  output logic      issue_ready_o,
  input  alu_op_t   issue_op_i,
  input  op_data_t  issue_rs1_i,
  input  op_data_t  issue_rs2_i,
  input  rob_idx_t  issue_dest_rob_idx_i,

  input  logic      cdb_valid_i,
  input  cdb_data_t cdb_data_i,
  output logic      cdb_valid_o,
  input  logic      cdb_ready_i,
  output cdb_data_t cdb_data_o
);

  logic    eu_req_valid, eu_res_valid;
  eu_req_t eu_req;
  eu_res_t eu_res;

  arith_rs #(.DEPTH(RS_DEPTH)) u_rs (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .issue_valid_i        (issue_valid_i),
    .issue_ready_o        (issue_ready_o),
    .issue_op_i           (issue_op_i),
    .issue_rs1_i          (issue_rs1_i),
    .issue_rs2_i          (issue_rs2_i),
    .issue_dest_rob_idx_i (issue_dest_rob_idx_i),
    .cdb_valid_i          (cdb_valid_i),
    .cdb_data_i           (cdb_data_i),
    .cdb_valid_o          (cdb_valid_o),
    .cdb_ready_i          (cdb_ready_i),
    .cdb_data_o           (cdb_data_o),
    .eu_req_valid_o       (eu_req_valid),
    .eu_req_o             (eu_req),
    .eu_res_valid_i       (eu_res_valid),
    .eu_res_i             (eu_res)
  );

  arith_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (eu_req_valid),
    .req_i       (eu_req),
    .res_valid_o (eu_res_valid),
    .res_o       (eu_res)
  );

endmodule

/* source/prio_enc.sv */
// Priority encoder
// Returns the index of the lowest set request line, with a flag
// telling whether any line is set at all

`timescale 1ns/1ps

module prio_enc #(
  parameter int unsigned N = 4
) (
  input  logic [N-1:0]         lines_i,
  output logic [$clog2(N)-1:0] enc_o,
  output logic                 valid_o
);

  // Scan from the top so the lowest set line is written last
  always_comb begin
    enc_o = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (lines_i[i]) begin
        enc_o = i[$clog2(N)-1:0];
      end
    end
  end

  assign valid_o = |lines_i;  // At least one request

endmodule

/* verilog.f */
+incdir+dv
common/arith_pkg.sv
source/prio_enc.sv
arith_rs/arith_alu.sv
arith_rs/arith_rs.sv
source/arith_cluster.sv
dv/tb_arith_cluster.sv
